// ==== verilog/rv_pkg.sv ====
// rv32i core shared definitions
package rv_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcodes kept by this core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no-op, unknown opcode
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset is scattered over two fields
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

endpackage

// ==== verilog/fetch_unit.sv ====
// instruction fetch and sequencing
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [rv_pkg::XLEN-1:0] reset_pc = rv_pkg::RESET_PC
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    fetch_req_valid,
    input  logic                    fetch_req_ready,
    output logic [rv_pkg::XLEN-1:0] fetch_addr,
    input  logic                    fetch_resp_valid,
    output logic                    fetch_resp_ready,
    input  logic [rv_pkg::XLEN-1:0] fetch_inst,
    input  logic                    advance,
    input  logic [rv_pkg::XLEN-1:0] next_pc,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    inst_valid,
    output rv_pkg::inst_word_u      inst
);

    typedef enum logic [1:0] {
        REQUEST,
        WAIT,
        EXEC,
        RETIRE
    } state_e;

    state_e state;
    state_e state_next;
    logic   req_fire;
    logic   resp_fire;

    assign req_fire  = fetch_req_valid && fetch_req_ready;
    assign resp_fire = fetch_resp_valid && fetch_resp_ready;

    always_comb begin
        state_next = state;
        case (state)
            REQUEST: if (req_fire) state_next = WAIT;
            WAIT:    if (resp_fire) state_next = EXEC;
            EXEC:    state_next = RETIRE;  // one cycle to decode/execute
            RETIRE:  if (advance) state_next = REQUEST;
            default: state_next = REQUEST;
        endcase
    end

    // handshake flags registered from the next state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= REQUEST;
            fetch_req_valid  <= 1'b0;
            fetch_resp_ready <= 1'b0;
            pc               <= reset_pc;
        end else begin
            state            <= state_next;
            fetch_req_valid  <= (state_next == REQUEST);
            fetch_resp_ready <= (state_next == WAIT);
            if (advance) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            inst <= fetch_inst;
        end
    end

    assign fetch_addr = pc;  // held until the request fires
    assign inst_valid = (state == EXEC);

endmodule

// ==== verilog/decode_unit.sv ====
// instruction decoder
`timescale 1ns/10ps

module decode_unit (
    input  rv_pkg::inst_word_u            inst,
    output rv_pkg::inst_type_e            inst_type,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd,
    output logic [2:0]                    funct3,
    output logic [rv_pkg::XLEN-1:0]       imm,
    output rv_pkg::alu_op_e               alu_op
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       alt_form;  // SUB / SRA selector bit

    assign opcode = inst.r_fmt.opcode;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign rd     = inst.r_fmt.rd;
    assign funct3 = inst.r_fmt.funct3;

    always_comb begin
        case (opcode)
            OP_REG:            inst_type = TYPE_R;
            OP_IMM, OP_JALR:   inst_type = TYPE_I;
            OP_BRANCH:         inst_type = TYPE_B;
            OP_LUI, OP_AUIPC:  inst_type = TYPE_U;
            OP_JAL:            inst_type = TYPE_J;
            default:           inst_type = TYPE_N;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (inst_type)
            TYPE_I: imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            TYPE_B: imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                           inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            TYPE_U: imm = {inst.u_fmt.imm_31_12, 12'h000};
            TYPE_J: imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                           inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // shifts by immediate carry the SRAI bit in imm[10]
    always_comb begin
        if (inst_type == TYPE_R) begin
            alt_form = (inst.r_fmt.funct7 == 7'b0100000);
        end else begin
            alt_form = inst.i_fmt.imm[10];
        end
    end

    always_comb begin
        alu_op = ALU_ADD;  // JALR, AUIPC and LUI all add
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (alt_form && inst_type == TYPE_R) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = alt_form ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// ==== verilog/execute_unit.sv ====
// execute stage, ALU and next pc
`timescale 1ns/10ps

module execute_unit (
    input  rv_pkg::inst_type_e            inst_type,
    input  logic [2:0]                    funct3,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  logic [rv_pkg::XLEN-1:0]       imm,
    input  rv_pkg::alu_op_e               alu_op,
    input  logic                          is_lui,
    input  logic                          is_jalr,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic                          wb_we,
    output logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic [rv_pkg::XLEN-1:0]       next_pc
);
    import rv_pkg::*;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] pc_target;   // branch and JAL target
    logic [XLEN-1:0] jalr_sum;
    logic            taken;
    logic            is_jump;

    assign seq_pc    = pc + 32'd4;
    assign pc_target = pc + imm;
    assign jalr_sum  = rs1_data + imm;
    assign is_jump   = (inst_type == TYPE_J) || (inst_type == TYPE_I && is_jalr);

    // operand select by format
    always_comb begin
        case (inst_type)
            TYPE_I: begin
                alu_a = rs1_data;
                alu_b = imm;
            end
            TYPE_U: begin
                alu_a = is_lui ? '0 : pc;  // AUIPC adds to pc
                alu_b = imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // branch condition on the raw register values
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;  // reserved encodings fall through
        endcase
    end

    always_comb begin
        next_pc = seq_pc;
        if (inst_type == TYPE_B && taken) begin
            next_pc = pc_target;
        end else if (inst_type == TYPE_J) begin
            next_pc = pc_target;
        end else if (inst_type == TYPE_I && is_jalr) begin
            next_pc = {jalr_sum[XLEN-1:1], 1'b0};
        end
    end

    assign wb_data = is_jump ? seq_pc : alu_result;

    // branches and unknown opcodes never write
    assign wb_we = (inst_type == TYPE_R || inst_type == TYPE_I ||
                    inst_type == TYPE_U || inst_type == TYPE_J) && (rd != '0);

endmodule

// ==== verilog/reg_file.sv ====
// general purpose register file
`timescale 1ns/10ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [rv_pkg::XLEN-1:0]       rdata1,
    output logic [rv_pkg::XLEN-1:0]       rdata2,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]       wdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== verilog/retire_unit.sv ====
// result register and retire handshake
`timescale 1ns/10ps

module retire_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inst_valid,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
    input  logic                          wb_we,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    input  logic [rv_pkg::XLEN-1:0]       next_pc_in,
    output logic                          retire_valid,
    input  logic                          retire_ready,
    output logic [rv_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic                          retire_we,
    output logic [rv_pkg::XLEN-1:0]       retire_data,
    output logic                          rf_we,
    output logic                          advance,
    output logic [rv_pkg::XLEN-1:0]       next_pc
);

    logic retire_fire;

    assign retire_fire = retire_valid && retire_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (inst_valid) begin
            retire_valid <= 1'b1;
        end else if (retire_fire) begin
            retire_valid <= 1'b0;
        end
    end

    // payload held stable while waiting on retire_ready
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire_pc   <= pc;
            retire_rd   <= rd;
            retire_we   <= wb_we;
            retire_data <= wb_data;
            next_pc     <= next_pc_in;
        end
    end

    assign rf_we   = retire_fire && retire_we;  // register write at retire
    assign advance = retire_fire;

endmodule

// ==== verilog/core_top.sv ====
// multicycle rv32i core top level
`timescale 1ns/10ps

module core_top #(
    parameter logic [rv_pkg::XLEN-1:0] reset_pc = rv_pkg::RESET_PC
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          fetch_req_valid,
    input  logic                          fetch_req_ready,
    output logic [rv_pkg::XLEN-1:0]       fetch_addr,
    input  logic                          fetch_resp_valid,
    output logic                          fetch_resp_ready,
    input  logic [rv_pkg::XLEN-1:0]       fetch_inst,
    output logic                          retire_valid,
    input  logic                          retire_ready,
    output logic [rv_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic                          retire_we,
    output logic [rv_pkg::XLEN-1:0]       retire_data
);
    import rv_pkg::*;

    logic                  advance;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       ret_next_pc;   // latched target back to fetch
    logic [XLEN-1:0]       exe_next_pc;
    logic                  inst_valid;
    inst_word_u            inst;
    inst_type_e            inst_type;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm;
    logic                  is_lui;
    logic                  is_jalr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  wb_we;
    logic [XLEN-1:0]       wb_data;
    logic                  rf_we;

    assign is_lui  = (inst.r_fmt.opcode == OP_LUI);
    assign is_jalr = (inst.r_fmt.opcode == OP_JALR);

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_addr      (fetch_addr),
        .fetch_resp_valid(fetch_resp_valid),
        .fetch_resp_ready(fetch_resp_ready),
        .fetch_inst      (fetch_inst),
        .advance         (advance),
        .next_pc         (ret_next_pc),
        .pc              (pc),
        .inst_valid      (inst_valid),
        .inst            (inst)
    );

    decode_unit u_decode (
        .inst     (inst),
        .inst_type(inst_type),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .funct3   (funct3),
        .imm      (imm),
        .alu_op   (alu_op)
    );

    reg_file u_regs (
        .clk   (clk),
        .reset (reset),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rs1_data),
        .rdata2(rs2_data),
        .we    (rf_we),
        .waddr (retire_rd),
        .wdata (retire_data)
    );

    execute_unit u_execute (
        .inst_type(inst_type),
        .funct3   (funct3),
        .rd       (rd),
        .imm      (imm),
        .alu_op   (alu_op),
        .is_lui   (is_lui),
        .is_jalr  (is_jalr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_data  (wb_data),
        .next_pc  (exe_next_pc)
    );

    retire_unit u_retire (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .pc          (pc),
        .rd          (rd),
        .wb_we       (wb_we),
        .wb_data     (wb_data),
        .next_pc_in  (exe_next_pc),
        .retire_valid(retire_valid),
        .retire_ready(retire_ready),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_we   (retire_we),
        .retire_data (retire_data),
        .rf_we       (rf_we),
        .advance     (advance),
        .next_pc     (ret_next_pc)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;  // released on an edge
    end

endmodule

// ==== verification/core_tb.sv ====
// rv32i core testbench
`timescale 1ns/10ps

module core_tb;
    import rv_pkg::*;

    localparam int N_INST          = 400;
    localparam int CLK_PERIOD      = 40;
    localparam int CYCLES_PER_INST = 40;
    localparam int WATCHDOG_NS     = N_INST * CYCLES_PER_INST * CLK_PERIOD;

    logic            clk;
    logic            reset;
    logic            fetch_req_valid;
    logic            fetch_req_ready;
    logic [31:0]     fetch_addr;
    logic            fetch_resp_valid;
    logic            fetch_resp_ready;
    logic [31:0]     fetch_inst;
    logic            retire_valid;
    logic            retire_ready;
    logic [31:0]     retire_pc;
    logic [4:0]      retire_rd;
    logic            retire_we;
    logic [31:0]     retire_data;

    int              seed;
    int              errors;
    int              checks;
    int              retire_count;
    logic [31:0]     model_regs [32];
    logic [31:0]     model_pc;
    logic [31:0]     fetch_pc;      // address of the instruction in flight
    logic [31:0]     pending;
    logic            have_resp;
    logic            in_flight;
    logic            exp_we;
    logic [4:0]      exp_rd;
    logic [31:0]     exp_data;
    logic [31:0]     exp_next_pc;

    tb_clock_gen #(
        .period(CLK_PERIOD)
    ) u_clk (
        .clk  (clk),
        .reset(reset)
    );

    core_top #(
        .reset_pc(RESET_PC)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_addr      (fetch_addr),
        .fetch_resp_valid(fetch_resp_valid),
        .fetch_resp_ready(fetch_resp_ready),
        .fetch_inst      (fetch_inst),
        .retire_valid    (retire_valid),
        .retire_ready    (retire_ready),
        .retire_pc       (retire_pc),
        .retire_rd       (retire_rd),
        .retire_we       (retire_we),
        .retire_data     (retire_data)
    );

    function automatic logic random_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // weighted mix, registers kept to x0..x7 for dependencies
    function automatic logic [31:0] random_instruction();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  bf3;
        logic [6:0]  f7;
        logic [6:0]  odd_op;
        int          kind;
        r    = $random(seed);
        kind = {$random(seed)} % 16;
        rd   = 5'({$random(seed)} % 8);
        rs1  = 5'({$random(seed)} % 8);
        rs2  = 5'({$random(seed)} % 8);
        f3   = r[14:12];
        f7   = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        bf3  = f3;
        if (bf3 == 3'b010 || bf3 == 3'b011) begin
            bf3[2] = 1'b1;  // no reserved branch encodings
        end
        case (r[1:0])
            2'd0:    odd_op = 7'b0000011;
            2'd1:    odd_op = 7'b0100011;
            2'd2:    odd_op = 7'b1110011;
            default: odd_op = 7'b0001111;
        endcase
        if (kind < 4) begin
            return {f7, rs2, rs1, f3, rd, OP_REG};
        end else if (kind < 8) begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                return {f7, r[24:20], rs1, f3, rd, OP_IMM};  // shift by immediate
            end
            return {r[31:20], rs1, f3, rd, OP_IMM};
        end else if (kind == 8) begin
            return {r[31:12], rd, OP_LUI};
        end else if (kind == 9) begin
            return {r[31:12], rd, OP_AUIPC};
        end else if (kind == 10) begin
            return {r[31:12], rd, OP_JAL};
        end else if (kind == 11) begin
            return {r[31:20], rs1, 3'b000, rd, OP_JALR};
        end else if (kind < 15) begin
            return {r[31:25], rs2, rs1, bf3, r[11:7], OP_BRANCH};
        end
        return {r[31:7], odd_op};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // reference result straight from the instruction bits
    task automatic predict_result(input logic [31:0] iw, input logic [31:0] ipc,
                                  output logic we, output logic [31:0] data,
                                  output logic [31:0] npc);
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        take;
        f3    = iw[14:12];
        a     = model_regs[iw[19:15]];
        b     = model_regs[iw[24:20]];
        imm_i = {{20{iw[31]}}, iw[31:20]};
        imm_b = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        we    = 1'b0;
        data  = 32'h0;
        npc   = ipc + 32'd4;
        take  = 1'b0;
        case (iw[6:0])
            OP_REG: begin
                we   = 1'b1;
                data = alu_model(f3, iw[30], a, b);
            end
            OP_IMM: begin
                we   = 1'b1;
                data = alu_model(f3, iw[30] && f3 == 3'b101, a, imm_i);  // only SRAI
            end
            OP_LUI: begin
                we   = 1'b1;
                data = {iw[31:12], 12'h000};
            end
            OP_AUIPC: begin
                we   = 1'b1;
                data = ipc + {iw[31:12], 12'h000};
            end
            OP_JAL: begin
                we   = 1'b1;
                data = ipc + 32'd4;
                npc  = ipc + imm_j;
            end
            OP_JALR: begin
                we   = 1'b1;
                data = ipc + 32'd4;
                npc  = (a + imm_i) & ~32'h1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) begin
                    npc = ipc + imm_b;
                end
            end
            default: ;  // unknown opcode, plain no-op
        endcase
        if (iw[11:7] == 5'd0) begin
            we = 1'b0;
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            fetch_req_ready  <= 1'b0;
            fetch_resp_valid <= 1'b0;
            retire_ready     <= 1'b0;
        end else begin
            if (fetch_req_valid && fetch_req_ready) begin
                assert (!in_flight) else begin
                    errors++;
                    $display("error at %0t: fetch request while an instruction is in flight",
                             $time);
                end
                if (retire_count == 0) begin
                    compare_word("first fetch address", fetch_addr, RESET_PC);
                end
                compare_word("fetch address", fetch_addr, model_pc);
                fetch_pc  = model_pc;
                pending   = random_instruction();
                have_resp = 1'b1;
                in_flight = 1'b1;
            end
            if (fetch_resp_valid && fetch_resp_ready) begin
                have_resp = 1'b0;
                exp_rd    = pending[11:7];
                predict_result(pending, fetch_pc, exp_we, exp_data, exp_next_pc);
            end
            if (retire_valid && retire_ready) begin
                assert (in_flight) else begin
                    errors++;
                    $display("error at %0t: retire without an instruction in flight", $time);
                end
                compare_word("retire pc", retire_pc, fetch_pc);
                compare_word("retire we", {31'b0, retire_we}, {31'b0, exp_we});
                if (exp_we) begin
                    compare_word("retire rd", {27'b0, retire_rd}, {27'b0, exp_rd});
                    compare_word("retire data", retire_data, exp_data);
                    model_regs[exp_rd] = exp_data;
                end
                model_pc  = exp_next_pc;
                in_flight = 1'b0;
                retire_count++;
            end
            fetch_req_ready  <= (retire_count < N_INST) && random_bit();
            fetch_resp_valid <= have_resp && random_bit();
            fetch_inst       <= pending;
            retire_ready     <= random_bit();
        end
    end

    initial begin
        seed         = 52;
        errors       = 0;
        checks       = 0;
        retire_count = 0;
        model_pc     = RESET_PC;
        fetch_pc     = RESET_PC;
        pending      = 32'h0;
        have_resp    = 1'b0;
        in_flight    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        fetch_req_ready  <= 1'b0;
        fetch_resp_valid <= 1'b0;
        fetch_inst       <= 32'h0;
        retire_ready     <= 1'b0;
        wait (retire_count == N_INST);
        repeat (20) @(posedge clk);  // room for a stray extra retire
        assert (retire_count == N_INST) else begin
            errors++;
            $display("error: %0d instructions retired, expected %0d", retire_count, N_INST);
        end
        $display("checks: %0d, errors: %0d, retired: %0d", checks, errors, retire_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        errors++;
        $display("error: the core stalled, watchdog expired after %0d of %0d retires",
                 retire_count, N_INST);
        $display("checks: %0d, errors: %0d, retired: %0d", checks, errors, retire_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
verilog/rv_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/reg_file.sv
verilog/retire_unit.sv
verilog/core_top.sv
verification/tb_clock_gen.sv
verification/core_tb.sv

// ==== Makefile ====
# Verilator simulation of the rv32i multicycle core

LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/Vcore_tb | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

build:
	verilator --binary --timing --assert -f all.f --top-module core_tb -o Vcore_tb

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module core_tb

clean:
	rm -rf obj_dir $(LOG)
